// ==== include/dbg_unit_params.svh ====
/*
 * Debug unit constants
 *   bus and data widths, region codes, debug register indices,
 *   settings bit positions and the requested-halt cause code
 */
`ifndef DBG_UNIT_PARAMS_SVH
`define DBG_UNIT_PARAMS_SVH

`define DBG_ADDR_W      15     // Debug bus address
`define DBG_DATA_W      32
`define DBG_GPR_AW      5      // Register file index
`define DBG_CAUSE_W     6
`define DBG_CAUSE_HALT  6'h1F  // Halt by request, no trap

// Region codes, address bits [13:8]
`define DBG_RGN_DBGA    6'h00  // Always accessible
`define DBG_RGN_DBGS    6'h20  // Only while halted
`define DBG_RGN_GPR     6'h04

`define DBG_REG_CTRL    5'd0
`define DBG_REG_HIT     5'd1
`define DBG_REG_IE      5'd2
`define DBG_REG_CAUSE   5'd3

`define DBG_SETS_W      5
`define DBG_SETS_SSTE   0      // Single step enable
`define DBG_SETS_ECALL  1
`define DBG_SETS_ELSU   2      // Load/store fault, two IE bits share it
`define DBG_SETS_EBRK   3
`define DBG_SETS_EILL   4

`endif

// ==== src/dbg_bus_pkg.sv ====
/*
 * Debug bus side types
 *   dbg_addr_u  bus address word, CSR view and debug register view
 *   dbg_rsel_e  source of the read data returned with rvalid
 */
`include "dbg_unit_params.svh"

package dbg_bus_pkg;

  // CSR view, kept for checking accesses to the CSR space
  typedef struct packed {
    logic        csr_flag;  // Bit 14
    logic [11:0] csr_num;   // Bits 13:2
    logic [1:0]  offset;    // Byte offset
  } dbg_addr_csr_t;

  // Debug register view, used by the decoder
  typedef struct packed {
    logic                   csr_flag;
    logic [5:0]             region;  // Bits 13:8
    logic                   spare;
    logic [`DBG_GPR_AW-1:0] idx;     // Word index, bits 6:2
    logic [1:0]             offset;
  } dbg_addr_dbg_t;

  typedef union packed {
    dbg_addr_csr_t csr;
    dbg_addr_dbg_t dbg;
  } dbg_addr_u;

  typedef enum logic [1:0] {
    DBG_RSEL_NONE,  // Refused or unmapped, reads zero
    DBG_RSEL_GPR,
    DBG_RSEL_DBGA,
    DBG_RSEL_DBGS
  } dbg_rsel_e;

endpackage

// ==== src/dbg_core_pkg.sv ====
/*
 * Core side types
 *   dbg_halt_state_e  run/halt-request/halted states
 *   dbg_cause_t       debug cause word
 */
`include "dbg_unit_params.svh"

package dbg_core_pkg;

  // ------------------------------------------------
  // Halt handshake with the core
  // ------------------------------------------------
  // RUN -> HALT_REQ on any halt source, dbg_req held
  // HALT_REQ -> HALTED on dbg_ack
  // HALT_REQ/HALTED -> RUN on resume
  typedef enum logic [1:0] {
    DBG_ST_RUN,
    DBG_ST_HALT_REQ,
    DBG_ST_HALTED
  } dbg_halt_state_e;

  // Exception cause from the core, or the requested-halt code
  typedef logic [`DBG_CAUSE_W-1:0] dbg_cause_t;

endpackage

// ==== src/dbg_if.sv ====
/*
 * Internal interfaces of the debug unit
 *   dbg_cmd_if  decoder strobes to the halt controller, halted back
 *   dbg_rd_if   request and state seen by the response stage
 */
`timescale 1ns/1ns
`include "dbg_unit_params.svh"

interface dbg_cmd_if;
  logic                   halt_set;    // One-cycle strobes
  logic                   resume_set;
  logic                   ctrl_wr;
  logic                   ie_wr;
  logic                   hit_clr;
  logic [`DBG_DATA_W-1:0] wdata;
  logic                   halted;      // Level from the FSM

  modport dec (output halt_set, resume_set, ctrl_wr, ie_wr, hit_clr, wdata, input halted);
  modport ctl (input halt_set, resume_set, ctrl_wr, ie_wr, hit_clr, wdata, output halted);
endinterface

interface dbg_rd_if;
  import dbg_bus_pkg::*;
  import dbg_core_pkg::*;

  // Decoder side, valid in the request cycle
  logic                   gnt;
  logic                   req;
  dbg_rsel_e              rsel_next;
  logic                   gpr_rd;
  logic                   jump;
  dbg_addr_u              addr;
  logic [`DBG_DATA_W-1:0] wdata;
  // Halt controller state for register reads
  logic [`DBG_SETS_W-1:0] settings;
  dbg_cause_t             cause;
  logic                   hit;
  logic                   halted;

  modport dec (output gnt, req, rsel_next, gpr_rd, jump, addr, wdata);
  modport ctl (output settings, cause, hit, halted);
  modport rsp (input gnt, req, rsel_next, gpr_rd, jump, addr, wdata,
               input settings, cause, hit, halted);
endinterface

// ==== src/dbg_access_decode.sv ====
/*
 * Debug bus access decoder
 *   grant, halt/resume/settings strobes, register file write,
 *   read source select and jump request for the response stage
 */
`timescale 1ns/1ns
`include "dbg_unit_params.svh"

module dbg_access_decode (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   debug_req_i,
  input  logic                   debug_we_i,
  input  dbg_bus_pkg::dbg_addr_u debug_addr_i,
  input  logic [`DBG_DATA_W-1:0] debug_wdata_i,
  output logic                   debug_gnt_o,
  output logic                   regfile_wreq_o,
  output logic [`DBG_GPR_AW-1:0] regfile_waddr_o,
  output logic [`DBG_DATA_W-1:0] regfile_wdata_o,
  dbg_cmd_if.dec                 cmd,
  dbg_rd_if.dec                  rd
);
  import dbg_bus_pkg::*;

  logic [5:0]             rgn;
  logic [`DBG_GPR_AW-1:0] idx;

  assign rgn = debug_addr_i.dbg.region;
  assign idx = debug_addr_i.dbg.idx;

  // Everything is granted, bus never blocks
  assign debug_gnt_o = debug_req_i;
  assign rd.gnt      = debug_req_i;
  assign rd.req      = debug_req_i;
  assign rd.addr     = debug_addr_i;
  assign rd.wdata    = debug_wdata_i;
  assign cmd.wdata   = debug_wdata_i;

  assign regfile_waddr_o = idx;
  assign regfile_wdata_o = debug_wdata_i;

  always_comb begin
    cmd.halt_set   = 1'b0;
    cmd.resume_set = 1'b0;
    cmd.ctrl_wr    = 1'b0;
    cmd.ie_wr      = 1'b0;
    cmd.hit_clr    = 1'b0;
    regfile_wreq_o = 1'b0;
    rd.rsel_next   = DBG_RSEL_NONE;
    rd.gpr_rd      = 1'b0;
    rd.jump        = 1'b0;

    // CSR space no longer mapped, granted and ignored
    if (debug_req_i && !debug_addr_i.dbg.csr_flag) begin
      if (debug_we_i) begin
        // ------------------------------------------------
        // Writes
        // ------------------------------------------------
        case (rgn)
          `DBG_RGN_DBGA: begin
            if (idx == `DBG_REG_CTRL) begin
              cmd.ctrl_wr    = 1'b1;                              // SSTE update
              cmd.halt_set   = debug_wdata_i[16] && !cmd.halted;
              cmd.resume_set = !debug_wdata_i[16] && cmd.halted;
            end
            if (idx == `DBG_REG_HIT) cmd.hit_clr = debug_wdata_i[0]; // Write 1 to clear
            if (idx == `DBG_REG_IE)  cmd.ie_wr   = 1'b1;
          end
          `DBG_RGN_DBGS: rd.jump = cmd.halted && (idx == 5'd0); // DNPC
          `DBG_RGN_GPR:  regfile_wreq_o = cmd.halted;
          default: ;
        endcase
      end else begin
        // Reads, data comes back with rvalid
        case (rgn)
          `DBG_RGN_DBGA: rd.rsel_next = DBG_RSEL_DBGA;
          `DBG_RGN_DBGS: rd.rsel_next = DBG_RSEL_DBGS;
          `DBG_RGN_GPR: begin
            rd.gpr_rd    = cmd.halted;                          // Refused while running
            rd.rsel_next = cmd.halted ? DBG_RSEL_GPR : DBG_RSEL_NONE;
          end
          default: ;
        endcase
      end
    end
  end

  // ------------------------------------------------
  // Bus usage checks
  // ------------------------------------------------
  a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    debug_req_i |-> debug_addr_i.dbg.offset == 2'b00);

  // Core internals only touched while halted
  a_halted_access: assert property (@(posedge clk) disable iff (!rst_n)
    debug_req_i && !cmd.halted |-> !debug_addr_i.csr.csr_flag &&
                                   debug_addr_i.csr.csr_num[11:6] != `DBG_RGN_DBGS);

endmodule

// ==== src/dbg_halt_ctrl.sv ====
/*
 * Halt controller
 *   run/halt-request/halted FSM with the core handshake,
 *   debug cause, single-step hit flag and settings register
 */
`timescale 1ns/1ns
`include "dbg_unit_params.svh"

module dbg_halt_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   debug_halt_i,
  input  logic                   debug_resume_i,
  input  logic                   trap_i,
  input  dbg_core_pkg::dbg_cause_t exc_cause_i,
  input  logic                   dbg_ack_i,
  output logic                   dbg_req_o,
  output logic                   stall_o,
  output logic                   debug_halted_o,
  output logic [`DBG_SETS_W-1:0] settings_o,
  dbg_cmd_if.ctl                 cmd,
  dbg_rd_if.ctl                  rd
);
  import dbg_core_pkg::*;

  dbg_halt_state_e        state_q, state_d;
  dbg_cause_t             cause_q, cause_d;
  logic                   hit_q, hit_d;
  logic [`DBG_SETS_W-1:0] sets_q, sets_d;
  logic                   resume;

  assign resume = cmd.resume_set | debug_resume_i;

  always_comb begin
    sets_d = sets_q;
    if (cmd.ctrl_wr) sets_d[`DBG_SETS_SSTE] = cmd.wdata[0];
    if (cmd.ie_wr) begin
      sets_d[`DBG_SETS_ECALL] = cmd.wdata[11];
      sets_d[`DBG_SETS_ELSU]  = cmd.wdata[7] | cmd.wdata[5];
      sets_d[`DBG_SETS_EBRK]  = cmd.wdata[3];
      sets_d[`DBG_SETS_EILL]  = cmd.wdata[2];
    end
  end

  // ------------------------------------------------
  // Halt FSM
  // ------------------------------------------------
  always_comb begin
    state_d        = state_q;
    cause_d        = cause_q;
    hit_d          = hit_q;
    dbg_req_o      = 1'b0;
    stall_o        = 1'b0;
    debug_halted_o = 1'b0;
    case (state_q)
      DBG_ST_RUN: begin
        hit_d = 1'b0;
        if (cmd.halt_set | debug_halt_i | trap_i) begin
          dbg_req_o = 1'b1;                         // Same cycle as the source
          state_d   = DBG_ST_HALT_REQ;
          cause_d   = trap_i ? exc_cause_i : dbg_cause_t'(`DBG_CAUSE_HALT);
          hit_d     = trap_i & sets_q[`DBG_SETS_SSTE];  // Step completed
        end
      end
      DBG_ST_HALT_REQ: begin
        dbg_req_o = 1'b1;                           // Held until ack
        if (dbg_ack_i) state_d = DBG_ST_HALTED;
        if (resume)    state_d = DBG_ST_RUN;
      end
      DBG_ST_HALTED: begin
        debug_halted_o = 1'b1;
        stall_o        = !resume;                   // Release core immediately
        if (resume) state_d = DBG_ST_RUN;
      end
      default: state_d = DBG_ST_RUN;
    endcase
    if (cmd.hit_clr) hit_d = 1'b0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= DBG_ST_RUN;
      cause_q <= dbg_cause_t'(`DBG_CAUSE_HALT);
      hit_q   <= 1'b0;
      sets_q  <= '0;
    end else begin
      state_q <= state_d;
      cause_q <= cause_d;
      hit_q   <= hit_d;
      sets_q  <= sets_d;
    end
  end

  assign settings_o  = sets_q;
  assign cmd.halted  = debug_halted_o;
  assign rd.halted   = debug_halted_o;
  assign rd.settings = sets_q;
  assign rd.cause    = cause_q;
  assign rd.hit      = hit_q;

  a_stall_halted: assert property (@(posedge clk) disable iff (!rst_n)
    stall_o |-> state_q == DBG_ST_HALTED && $past(dbg_req_o || stall_o || resume));

endmodule

// ==== src/dbg_resp.sv ====
/*
 * Debug bus response stage
 *   registered read select, address and write data,
 *   debug register read data, read mux, rvalid,
 *   delayed register file read and DNPC jump requests
 */
`timescale 1ns/1ns
`include "dbg_unit_params.svh"

module dbg_resp (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`DBG_DATA_W-1:0] pc_if_i,
  input  logic [`DBG_DATA_W-1:0] pc_id_i,
  input  logic [`DBG_DATA_W-1:0] regfile_rdata_i,
  output logic                   regfile_rreq_o,
  output logic [`DBG_GPR_AW-1:0] regfile_raddr_o,
  output logic                   jump_req_o,
  output logic [`DBG_DATA_W-1:0] jump_addr_o,
  output logic                   debug_rvalid_o,
  output logic [`DBG_DATA_W-1:0] debug_rdata_o,
  dbg_rd_if.rsp                  rd
);
  import dbg_bus_pkg::*;

  dbg_rsel_e              rsel_q;
  dbg_addr_u              addr_q;
  logic [`DBG_DATA_W-1:0] wdata_q;  // Jump target
  logic [`DBG_DATA_W-1:0] dbg_rdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsel_q         <= DBG_RSEL_NONE;
      regfile_rreq_o <= 1'b0;
      jump_req_o     <= 1'b0;
      debug_rvalid_o <= 1'b0;
    end else begin
      debug_rvalid_o <= rd.gnt;      // One cycle after every grant
      if (rd.req | debug_rvalid_o) begin // Pulses drop after one cycle
        rsel_q         <= rd.rsel_next;
        regfile_rreq_o <= rd.gpr_rd;
        jump_req_o     <= rd.jump;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd.req) begin
      addr_q  <= rd.addr;
      wdata_q <= rd.wdata;
    end
  end

  // ------------------------------------------------
  // Debug register read data
  // ------------------------------------------------
  always_comb begin
    dbg_rdata = '0;
    if (rsel_q == DBG_RSEL_DBGA) begin
      case (addr_q.dbg.idx)
        `DBG_REG_CTRL: begin
          dbg_rdata[16] = rd.halted;
          dbg_rdata[0]  = rd.settings[`DBG_SETS_SSTE];
        end
        `DBG_REG_HIT: dbg_rdata[0] = rd.hit;
        `DBG_REG_IE: begin
          dbg_rdata[11] = rd.settings[`DBG_SETS_ECALL];
          dbg_rdata[7]  = rd.settings[`DBG_SETS_ELSU];  // Mirrored at 7 and 5
          dbg_rdata[5]  = rd.settings[`DBG_SETS_ELSU];
          dbg_rdata[3]  = rd.settings[`DBG_SETS_EBRK];
          dbg_rdata[2]  = rd.settings[`DBG_SETS_EILL];
        end
        `DBG_REG_CAUSE:
          dbg_rdata = {rd.cause[`DBG_CAUSE_W-1], 26'b0, rd.cause[`DBG_CAUSE_W-2:0]};
        default: ;
      endcase
    end else if (rsel_q == DBG_RSEL_DBGS) begin
      if (addr_q.dbg.idx == 5'd0) dbg_rdata = pc_if_i;  // NPC
      if (addr_q.dbg.idx == 5'd1) dbg_rdata = pc_id_i;  // PPC
    end
  end

  // Register file data is combinational from the registered index
  assign debug_rdata_o   = (rsel_q == DBG_RSEL_GPR) ? regfile_rdata_i : dbg_rdata;
  assign regfile_raddr_o = addr_q.dbg.idx;
  assign jump_addr_o     = wdata_q;

  // Each rvalid answers a request whose select and address were registered
  a_rvalid_per_req: assert property (@(posedge clk) disable iff (!rst_n)
    debug_rvalid_o |-> $past(rd.req));

endmodule

// ==== src/dbg_unit.sv ====
/*
 * Debug unit top level
 *   access decoder, halt controller and response stage
 *   joined by the command and read interfaces
 */
`timescale 1ns/1ns
`include "dbg_unit_params.svh"

module dbg_unit (
  input  logic                    clk,
  input  logic                    rst_n,
  // Debug bus
  input  logic                    debug_req_i,
  output logic                    debug_gnt_o,
  output logic                    debug_rvalid_o,
  input  logic [`DBG_ADDR_W-1:0]  debug_addr_i,
  input  logic                    debug_we_i,
  input  logic [`DBG_DATA_W-1:0]  debug_wdata_i,
  output logic [`DBG_DATA_W-1:0]  debug_rdata_o,
  // External halt control
  output logic                    debug_halted_o,
  input  logic                    debug_halt_i,
  input  logic                    debug_resume_i,
  // Core side
  output logic [`DBG_SETS_W-1:0]  settings_o,
  input  logic                    trap_i,
  input  logic [`DBG_CAUSE_W-1:0] exc_cause_i,
  output logic                    stall_o,
  output logic                    dbg_req_o,
  input  logic                    dbg_ack_i,
  // Register file ports
  output logic                    regfile_rreq_o,
  output logic [`DBG_GPR_AW-1:0]  regfile_raddr_o,
  input  logic [`DBG_DATA_W-1:0]  regfile_rdata_i,
  output logic                    regfile_wreq_o,
  output logic [`DBG_GPR_AW-1:0]  regfile_waddr_o,
  output logic [`DBG_DATA_W-1:0]  regfile_wdata_o,
  // PCs and DNPC jump
  input  logic [`DBG_DATA_W-1:0]  pc_if_i,
  input  logic [`DBG_DATA_W-1:0]  pc_id_i,
  output logic                    jump_req_o,
  output logic [`DBG_DATA_W-1:0]  jump_addr_o
);

  dbg_cmd_if cmd_if ();
  dbg_rd_if  rd_if ();

  dbg_access_decode u_decode (
    .clk, .rst_n, .debug_req_i, .debug_we_i, .debug_addr_i, .debug_wdata_i,
    .debug_gnt_o, .regfile_wreq_o, .regfile_waddr_o, .regfile_wdata_o,
    .cmd (cmd_if.dec),
    .rd  (rd_if.dec)
  );

  dbg_halt_ctrl u_halt (
    .clk, .rst_n, .debug_halt_i, .debug_resume_i, .trap_i, .exc_cause_i,
    .dbg_ack_i, .dbg_req_o, .stall_o, .debug_halted_o, .settings_o,
    .cmd (cmd_if.ctl),
    .rd  (rd_if.ctl)
  );

  dbg_resp u_resp (
    .clk, .rst_n, .pc_if_i, .pc_id_i, .regfile_rdata_i, .regfile_rreq_o,
    .regfile_raddr_o, .jump_req_o, .jump_addr_o, .debug_rvalid_o, .debug_rdata_o,
    .rd  (rd_if.rsp)
  );

endmodule

// ==== sim/tb_clk_gen.sv ====
/*
 * Testbench clock and reset
 *   free running clock, active low reset released on a falling edge
 */
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);                // Release away from the active edge
    rst_n_o = 1'b1;
  end

endmodule

// ==== sim/dbg_unit_tb.sv ====
/*
 * Debug unit testbench
 *   pattern file reader and step runner, register file model,
 *   halt acknowledge, grant/rvalid/jump/read request monitors,
 *   compare tasks and cycle limit
 */
`timescale 1ns/1ns
`include "dbg_unit_params.svh"

module dbg_unit_tb;
  import dbg_core_pkg::*;

  localparam int          RST_CYCLES  = 16;
  localparam int          MAX_STEPS   = 64;
  localparam int          STEP_CYCLES = 10;      // Budget per pattern line
  localparam int          FLAG_WAIT   = 6;       // Cycles to reach a halt state
  localparam logic [31:0] PC_IF       = 32'h0000_1A40;
  localparam logic [31:0] PC_ID       = 32'h0000_1A3C;

  // Pattern operation codes
  localparam logic [3:0] OP_WRITE  = 4'h1;
  localparam logic [3:0] OP_READ   = 4'h2;
  localparam logic [3:0] OP_HALT   = 4'h3;
  localparam logic [3:0] OP_RESUME = 4'h4;
  localparam logic [3:0] OP_TRAP   = 4'h5;
  localparam logic [3:0] OP_JUMP   = 4'h6;
  localparam logic [3:0] OP_FLAGS  = 4'h7;
  localparam logic [3:0] OP_SETS   = 4'h8;
  localparam logic [3:0] OP_CAUSE  = 4'h9;
  localparam logic [3:0] OP_MODEL  = 4'hA;

  logic                    clk;
  logic                    rst_n;
  logic                    debug_req_i;
  logic                    debug_gnt_o;
  logic                    debug_rvalid_o;
  logic [`DBG_ADDR_W-1:0]  debug_addr_i;
  logic                    debug_we_i;
  logic [`DBG_DATA_W-1:0]  debug_wdata_i;
  logic [`DBG_DATA_W-1:0]  debug_rdata_o;
  logic                    debug_halted_o;
  logic                    debug_halt_i;
  logic                    debug_resume_i;
  logic [`DBG_SETS_W-1:0]  settings_o;
  logic                    trap_i;
  logic [`DBG_CAUSE_W-1:0] exc_cause_i;
  logic                    stall_o;
  logic                    dbg_req_o;
  logic                    dbg_ack_i = 1'b0;
  logic                    regfile_rreq_o;
  logic [`DBG_GPR_AW-1:0]  regfile_raddr_o;
  logic [`DBG_DATA_W-1:0]  regfile_rdata_i;
  logic                    regfile_wreq_o;
  logic [`DBG_GPR_AW-1:0]  regfile_waddr_o;
  logic [`DBG_DATA_W-1:0]  regfile_wdata_o;
  logic [`DBG_DATA_W-1:0]  pc_if_i;
  logic [`DBG_DATA_W-1:0]  pc_id_i;
  logic                    jump_req_o;
  logic [`DBG_DATA_W-1:0]  jump_addr_o;

  logic [31:0]            pat_mem [0:4*MAX_STEPS-1];  // op, addr, data, expected
  logic [`DBG_DATA_W-1:0] rf_model [0:31];
  logic                   req_seen = 1'b0;
  logic [`DBG_DATA_W-1:0] jump_last = '0;
  int                     jump_count = 0;
  int                     rreq_count = 0;
  int                     gnt_count = 0;
  int                     rvalid_count = 0;
  int                     err_count = 0;
  int                     cycle_count = 0;
  int                     timeout_limit = 0;

  tb_clk_gen #(.PERIOD_NS(20), .RST_CYCLES(RST_CYCLES)) clk_gen_i (.clk_o(clk), .rst_n_o(rst_n));

  dbg_unit dbg_unit_i (.*);

  assign pc_if_i         = PC_IF;
  assign pc_id_i         = PC_ID;
  assign regfile_rdata_i = rf_model[regfile_raddr_o];  // Combinational read port

  // Register file, filled from the index during reset
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) rf_model[i] <= 32'h5A5A_0000 | 32'(i);
    end else if (regfile_wreq_o) begin
      rf_model[regfile_waddr_o] <= regfile_wdata_o;
    end
  end

  // ------------------------------------------------
  // Core handshake and bus monitors
  // ------------------------------------------------
  always @(posedge clk) req_seen <= dbg_req_o;
  always @(negedge clk) dbg_ack_i <= rst_n && req_seen && !dbg_ack_i;  // One-cycle ack

  always @(posedge clk) begin
    if (rst_n && debug_gnt_o) gnt_count <= gnt_count + 1;
  end

  always @(negedge clk) begin
    if (rst_n && debug_rvalid_o) rvalid_count <= rvalid_count + 1;
    if (rst_n && regfile_rreq_o) rreq_count <= rreq_count + 1;
    if (rst_n && jump_req_o) begin
      jump_count <= jump_count + 1;
      jump_last  <= jump_addr_o;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      $display("Timeout: the pattern steps did not finish within %0d cycles", timeout_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ------------------------------------------------
  // Compare tasks
  // ------------------------------------------------
  task automatic check_word(input string what, input logic [`DBG_DATA_W-1:0] got,
                            input logic [`DBG_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_cause(input string what, input dbg_cause_t got, input dbg_cause_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
      err_count++;
    end
  endtask

  // One bus access, rvalid exactly one cycle after the grant
  task automatic bus_access(input logic we, input logic [`DBG_ADDR_W-1:0] addr,
                            input logic [`DBG_DATA_W-1:0] wdata,
                            output logic [`DBG_DATA_W-1:0] rdata);
    logic gnt_seen;
    logic rvalid_seen;
    @(negedge clk);
    debug_req_i   = 1'b1;
    debug_we_i    = we;
    debug_addr_i  = addr;
    debug_wdata_i = wdata;
    @(posedge clk);
    gnt_seen = debug_gnt_o;          // Combinational from the request
    @(negedge clk);
    rvalid_seen = debug_rvalid_o;
    rdata       = debug_rdata_o;
    debug_req_i = 1'b0;
    debug_we_i  = 1'b0;
    check_flag("grant in request cycle", gnt_seen, 1'b1);
    check_flag("rvalid after grant", rvalid_seen, 1'b1);
    @(negedge clk);
    check_flag("rvalid without grant", debug_rvalid_o, 1'b0);
  endtask

  function automatic string op_name(input logic [3:0] op);
    case (op)
      OP_WRITE:  return "bus write";
      OP_READ:   return "bus read";
      OP_HALT:   return "halt pin";
      OP_RESUME: return "resume pin";
      OP_TRAP:   return "trap";
      OP_JUMP:   return "DNPC jump";
      OP_FLAGS:  return "halt flags";
      OP_SETS:   return "settings";
      OP_CAUSE:  return "cause";
      OP_MODEL:  return "regfile entry";
      default:   return "unknown";
    endcase
  endfunction

  // ------------------------------------------------
  // Step runner
  // ------------------------------------------------
  initial begin
    logic [31:0]            op;
    logic [31:0]            addr;
    logic [31:0]            data;
    logic [31:0]            exp;
    logic [`DBG_DATA_W-1:0] rdata;
    logic                   model_halted;
    int                     n_steps;
    int                     errs_before;
    int                     jumps_before;
    int                     rreqs_before;
    int                     pass_count;
    int                     n;
    debug_req_i    = 1'b0;
    debug_we_i     = 1'b0;
    debug_addr_i   = '0;
    debug_wdata_i  = '0;
    debug_halt_i   = 1'b0;
    debug_resume_i = 1'b0;
    trap_i         = 1'b0;
    exc_cause_i    = '0;
    pass_count     = 0;
    model_halted   = 1'b0;                                   // Core runs out of reset
    for (int i = 0; i < 4 * MAX_STEPS; i++) pat_mem[i] = 32'd0;  // Op 0 ends the list
    $readmemh("sim/dbg_unit_patterns.txt", pat_mem);
    n_steps = 0;
    while (n_steps < MAX_STEPS && pat_mem[4*n_steps] != 32'd0) n_steps++;
    if (n_steps == 0) begin
      $display("No test steps could be read from the pattern file");
      err_count++;
    end
    timeout_limit = n_steps * STEP_CYCLES + RST_CYCLES;

    wait (rst_n === 1'b1);
    for (int s = 0; s < n_steps; s++) begin
      op          = pat_mem[4*s];
      addr        = pat_mem[4*s+1];
      data        = pat_mem[4*s+2];
      exp         = pat_mem[4*s+3];
      errs_before = err_count;
      case (op[3:0])
        OP_WRITE: begin
          bus_access(1'b1, addr[14:0], data, rdata);
          // DBG_CTRL bit 16 halts or resumes
          if (addr[14:8] == 7'd0 && addr[6:2] == `DBG_REG_CTRL) model_halted = data[16];
        end
        OP_READ: begin
          rreqs_before = rreq_count;
          bus_access(1'b0, addr[14:0], 32'd0, rdata);
          check_word($sformatf("read data at %04h", addr[14:0]), rdata, exp);
          check_word("regfile_rreq_o pulses", 32'(rreq_count - rreqs_before),
                     (!addr[14] && addr[13:8] == `DBG_RGN_GPR && model_halted) ?
                     32'd1 : 32'd0);
        end
        OP_HALT, OP_RESUME, OP_TRAP: begin
          @(negedge clk);
          debug_halt_i   = (op[3:0] == OP_HALT);
          debug_resume_i = (op[3:0] == OP_RESUME);
          trap_i         = (op[3:0] == OP_TRAP);
          exc_cause_i    = data[5:0];
          @(posedge clk);
          if (op[3:0] != OP_RESUME) begin
            check_flag("dbg_req_o with the halt source", dbg_req_o, !model_halted);
          end
          @(negedge clk);
          debug_halt_i   = 1'b0;
          debug_resume_i = 1'b0;
          trap_i         = 1'b0;
          model_halted   = (op[3:0] != OP_RESUME);
        end
        OP_JUMP: begin
          jumps_before = jump_count;
          bus_access(1'b1, addr[14:0], data, rdata);
          @(negedge clk);
          check_word("jump_req_o pulses", 32'(jump_count - jumps_before), 32'd1);
          check_word("jump_addr_o", jump_last, exp);
        end
        OP_FLAGS: begin
          n = 0;
          while (debug_halted_o !== exp[0] && n < FLAG_WAIT) begin
            @(negedge clk);
            n++;
          end
          check_flag("debug_halted_o", debug_halted_o, exp[0]);
          check_flag("stall_o", stall_o, exp[1]);
        end
        OP_SETS: begin
          for (int b = 0; b < `DBG_SETS_W; b++) begin
            check_flag($sformatf("settings_o[%0d]", b), settings_o[b], exp[b]);
          end
        end
        OP_CAUSE: begin
          bus_access(1'b0, addr[14:0], 32'd0, rdata);
          check_cause("DBG_CAUSE", {rdata[31], rdata[4:0]}, exp[5:0]);  // Bit 5 sits at 31
          check_word("DBG_CAUSE unused bits", rdata & 32'h7FFF_FFE0, 32'd0);
        end
        OP_MODEL: begin
          check_word($sformatf("register file entry %0d", addr[4:0]),
                     rf_model[addr[4:0]], exp);
        end
        default: begin
          $display("Step %0d has the unknown operation code %0h", s, op);
          err_count++;
        end
      endcase
      if (err_count == errs_before) pass_count++;
      $display("Step %2d %s %s", s, op_name(op[3:0]),
               (err_count == errs_before) ? "ok" : "failed");
    end

    @(negedge clk);
    check_word("rvalid count against grants", 32'(rvalid_count), 32'(gnt_count));
    $display("Steps %0d, passed %0d, failed %0d, errors %0d",
             n_steps, pass_count, n_steps - pass_count, err_count);
    if (err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== dbg_unit.f ====
+incdir+include
src/dbg_bus_pkg.sv
src/dbg_core_pkg.sv
src/dbg_if.sv
src/dbg_access_decode.sv
src/dbg_halt_ctrl.sv
src/dbg_resp.sv
src/dbg_unit.sv
sim/tb_clk_gen.sv
sim/dbg_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the debug unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
  --top-module dbg_unit_tb -f dbg_unit.f -Mdir obj_dir -o dbg_unit_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/dbg_unit_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q '^SIMULATION PASSED$'; then
  exit 0
fi
exit 1

// ==== sim/dbg_unit_patterns.txt ====
// Columns: op addr data expected, all hex, one test step per line
// op 1 write, 2 read, 3 halt pin, 4 resume pin, 5 trap (data = cause),
// op 6 DNPC write and jump check, 7 halted/stall (bit 0/1), 8 settings_o,
// op 9 cause read, A register file entry (addr = index)
3 0000 00000000 00000000
7 0000 00000000 00000003
9 000C 00000000 0000001F
2 000C 00000000 0000001F
2 0000 00000000 00010000
1 0008 FFFFF884 00000000
2 0008 00000000 000008A4
8 0000 00000000 00000016
1 041C CAFE0007 00000000
A 0007 00000000 CAFE0007
2 041C 00000000 CAFE0007
2 2000 00000000 00001A40
2 2004 00000000 00001A3C
6 2000 00002200 00002200
1 0000 00000000 00000000
7 0000 00000000 00000000
2 0000 00000000 00000000
1 0424 DEAD0009 00000000
A 0009 00000000 5A5A0009
2 0424 00000000 00000000
1 0000 00000001 00000000
5 0000 0000002B 00000000
7 0000 00000000 00000003
2 0004 00000000 00000001
9 000C 00000000 0000002B
1 0004 00000001 00000000
2 0004 00000000 00000000
4 0000 00000000 00000000
7 0000 00000000 00000000
2 0000 00000000 00000001
